/* hdl/gfx_consts.svh */
`ifndef GFX_CONSTS_SVH
`define GFX_CONSTS_SVH

// horizontal timing, in clock cycles from the start of a line
`define GFX_H_VISIBLE    16
`define GFX_H_SYNC_START 18
`define GFX_H_SYNC_END   21
`define GFX_H_LINE_END   23

// vertical timing, in lines from the top of a frame
`define GFX_V_VISIBLE    8
`define GFX_V_SYNC_START 9
`define GFX_V_SYNC_END   11
`define GFX_V_FRAME_END  11

// writer queue depth, also the generator's starting credit count
`define GFX_CREDITS      4

// one word per visible pixel
`define GFX_FB_DEPTH     128

`endif

/* hdl/gfx_pkg.sv */
`default_nettype none

package gfx_pkg;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  typedef struct packed {
    logic [4:0] x;
    logic [3:0] y;
  } coord_t;

  // word carried on the credit channel
  typedef struct packed {
    coord_t coord;
    pixel_t pixel;
  } pixel_req_t;

  typedef enum logic [1:0] {
    PAT_SOLID    = 2'd0,
    PAT_BARS     = 2'd1,
    PAT_CHECKER  = 2'd2,
    PAT_GRADIENT = 2'd3
  } pattern_e;

  typedef enum logic [1:0] {
    FILL_IDLE  = 2'd0,
    FILL_RUN   = 2'd1,
    FILL_DRAIN = 2'd2
  } fill_state_e;

  typedef struct packed {
    pixel_t color;
    logic   hsync;  // active low
    logic   vsync;  // active low
    logic   de;
  } vga_t;

  typedef logic [6:0] fb_addr_t;

endpackage

`default_nettype wire

/* hdl/gfx_pattern.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_consts.svh"

module gfx_pattern (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  gfx_pkg::pattern_e   mode,
  input  gfx_pkg::pixel_t     color,
  input  logic                credit_return,
  output logic                req_valid,
  output gfx_pkg::pixel_req_t req,
  output logic                busy,
  output logic                fill_done
);

  gfx_pkg::fill_state_e state;
  gfx_pkg::pattern_e    mode_q;
  gfx_pkg::pixel_t      color_q;
  gfx_pkg::pixel_t      pix;
  logic [4:0]           x;
  logic [3:0]           y;
  logic [2:0]           credits;
  logic [2:0]           bar;
  logic                 last_pix;

  assign bar      = x[3:1];  // bars are two pixels wide
  assign last_pix = (x == 5'(`GFX_H_VISIBLE - 1)) && (y == 4'(`GFX_V_VISIBLE - 1));

  always_comb begin
    pix = '0;
    case (mode_q)
      gfx_pkg::PAT_SOLID: pix = color_q;
      gfx_pkg::PAT_BARS: begin
        pix.red   = {4{bar[0]}};
        pix.green = {4{bar[1]}};
        pix.blue  = {4{bar[2]}};
      end
      gfx_pkg::PAT_CHECKER: begin
        if (x[2] != y[2]) begin
          pix = color_q;
        end
      end
      gfx_pkg::PAT_GRADIENT: begin
        pix.red   = x[3:0];
        pix.green = {y[2:0], 1'b0};
        pix.blue  = x[3:0] + y;  // wraps mod 16
      end
      default: pix = '0;
    endcase
  end

  assign req_valid       = (state == gfx_pkg::FILL_RUN) && (credits != 3'd0);
  assign req.coord.x     = x;
  assign req.coord.y     = y;
  assign req.pixel       = pix;
  assign busy            = (state != gfx_pkg::FILL_IDLE);
  assign fill_done       = (state == gfx_pkg::FILL_DRAIN) && (credits == 3'(`GFX_CREDITS));

  // start is only taken while idle so a restart mid-fill is ignored
  always_ff @(posedge clk) begin
    if (start && state == gfx_pkg::FILL_IDLE) begin
      mode_q  <= mode;
      color_q <= color;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= gfx_pkg::FILL_IDLE;
      x       <= '0;
      y       <= '0;
      credits <= 3'(`GFX_CREDITS);
    end else begin
      credits <= credits + {2'b00, credit_return} - {2'b00, req_valid};
      case (state)
        gfx_pkg::FILL_IDLE: begin
          if (start) begin
            x     <= '0;
            y     <= '0;
            state <= gfx_pkg::FILL_RUN;
          end
        end
        gfx_pkg::FILL_RUN: begin
          if (req_valid) begin
            if (last_pix) begin
              state <= gfx_pkg::FILL_DRAIN;
            end else if (x == 5'(`GFX_H_VISIBLE - 1)) begin
              x <= '0;
              y <= y + 4'd1;
            end else begin
              x <= x + 5'd1;
            end
          end
        end
        gfx_pkg::FILL_DRAIN: begin
          if (fill_done) begin
            state <= gfx_pkg::FILL_IDLE;  // every pixel is in memory
          end
        end
        default: state <= gfx_pkg::FILL_IDLE;
      endcase
    end
  end

  // writer must never hand back more credits than were spent
  a_credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credits <= 3'(`GFX_CREDITS));

  // every credit is home while idle
  a_idle_credits_home: assert property (@(posedge clk) disable iff (!rst_n)
    !busy |-> credits == 3'(`GFX_CREDITS));

endmodule

`default_nettype wire

/* hdl/gfx_fb_writer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_consts.svh"

module gfx_fb_writer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                req_valid,
  input  gfx_pkg::pixel_req_t req,
  output logic                credit_return,
  output logic                wr_en,
  output gfx_pkg::fb_addr_t   wr_addr,
  output gfx_pkg::pixel_t     wr_data
);

  localparam int DEPTH = `GFX_CREDITS;

  gfx_pkg::pixel_req_t queue [DEPTH];
  gfx_pkg::pixel_req_t head;
  logic [1:0]          wr_ptr;
  logic [1:0]          rd_ptr;
  logic [2:0]          count;
  logic                full;
  logic                pop;

  assign full = (count == 3'(DEPTH));
  assign pop  = (count != 3'd0);  // drain one entry every cycle
  assign head = queue[rd_ptr];

  // linear address is y*16 + x, the line width is a power of two
  assign wr_en         = pop;
  assign wr_addr       = {head.coord.y[2:0], head.coord.x[3:0]};
  assign wr_data       = head.pixel;
  assign credit_return = pop;

  always_ff @(posedge clk) begin
    if (req_valid) begin
      queue[wr_ptr] <= req;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (req_valid) begin
        wr_ptr <= wr_ptr + 2'd1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 2'd1;
      end
      count <= count + {2'b00, req_valid} - {2'b00, pop};
    end
  end

  // credits on the generator side keep this from ever firing
  a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> !full);

  a_coord_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    req_valid |-> (req.coord.x < 5'(`GFX_H_VISIBLE)) && (req.coord.y < 4'(`GFX_V_VISIBLE)));

endmodule

`default_nettype wire

/* hdl/gfx_fb_mem.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_consts.svh"

module gfx_fb_mem (
  input  logic              clk,
  input  logic              wr_en,
  input  gfx_pkg::fb_addr_t wr_addr,
  input  gfx_pkg::pixel_t   wr_data,
  input  gfx_pkg::fb_addr_t rd_addr,
  output gfx_pkg::pixel_t   rd_data
);

  gfx_pkg::pixel_t mem [`GFX_FB_DEPTH];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, data one cycle after the address
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

/* hdl/gfx_scanout.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_consts.svh"

module gfx_scanout (
  input  logic              clk,
  input  logic              rst_n,
  output gfx_pkg::fb_addr_t rd_addr,
  input  gfx_pkg::pixel_t   rd_data,
  output gfx_pkg::vga_t     vga
);

  logic [4:0] h;
  logic [3:0] v;
  logic       de0;
  logic       hs0;
  logic       vs0;
  logic       de1;
  logic       hs1;
  logic       vs1;

  assign de0 = (h < 5'(`GFX_H_VISIBLE)) && (v < 4'(`GFX_V_VISIBLE));
  assign hs0 = !((h >= 5'(`GFX_H_SYNC_START)) && (h < 5'(`GFX_H_SYNC_END)));
  assign vs0 = !((v >= 4'(`GFX_V_SYNC_START)) && (v < 4'(`GFX_V_SYNC_END)));

  // address only while in the visible area
  assign rd_addr = de0 ? {v[2:0], h[3:0]} : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      h <= '0;
      v <= '0;
    end else if (h == 5'(`GFX_H_LINE_END)) begin
      h <= '0;
      if (v == 4'(`GFX_V_FRAME_END)) begin
        v <= '0;
      end else begin
        v <= v + 4'd1;
      end
    end else begin
      h <= h + 5'd1;
    end
  end

  // stage 1 waits for the memory read and stage 2 drives the pins
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      de1       <= 1'b0;
      hs1       <= 1'b1;
      vs1       <= 1'b1;
      vga.color <= '0;
      vga.hsync <= 1'b1;
      vga.vsync <= 1'b1;
      vga.de    <= 1'b0;
    end else begin
      de1       <= de0;
      hs1       <= hs0;
      vs1       <= vs0;
      vga.color <= de1 ? rd_data : '0;  // blank outside the visible area
      vga.hsync <= hs1;
      vga.vsync <= vs1;
      vga.de    <= de1;
    end
  end

  // sync pulses sit in the blanking interval
  a_de_outside_sync: assert property (@(posedge clk) disable iff (!rst_n)
    vga.de |-> vga.hsync && vga.vsync);

endmodule

`default_nettype wire

/* hdl/gfx_pattern_top.sv */
`timescale 1ns/10ps
`default_nettype none

module gfx_pattern_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  gfx_pkg::pattern_e mode,
  input  gfx_pkg::pixel_t   color,
  output logic              busy,
  output logic              fill_done,
  output gfx_pkg::vga_t     vga
);

  logic                req_valid;
  gfx_pkg::pixel_req_t req;
  logic                credit_return;
  logic                wr_en;
  gfx_pkg::fb_addr_t   wr_addr;
  gfx_pkg::pixel_t     wr_data;
  gfx_pkg::fb_addr_t   rd_addr;
  gfx_pkg::pixel_t     rd_data;

  gfx_pattern i_gfx_pattern (
    .clk          (clk),
    .rst_n        (rst_n),
    .start        (start),
    .mode         (mode),
    .color        (color),
    .credit_return(credit_return),
    .req_valid    (req_valid),
    .req          (req),
    .busy         (busy),
    .fill_done    (fill_done)
  );

  gfx_fb_writer i_gfx_fb_writer (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .req          (req),
    .credit_return(credit_return),
    .wr_en        (wr_en),
    .wr_addr      (wr_addr),
    .wr_data      (wr_data)
  );

  gfx_fb_mem i_gfx_fb_mem (
    .clk    (clk),
    .wr_en  (wr_en),
    .wr_addr(wr_addr),
    .wr_data(wr_data),
    .rd_addr(rd_addr),
    .rd_data(rd_data)
  );

  // free running, shows whatever the memory holds
  gfx_scanout i_gfx_scanout (
    .clk    (clk),
    .rst_n  (rst_n),
    .rd_addr(rd_addr),
    .rd_data(rd_data),
    .vga    (vga)
  );

endmodule

`default_nettype wire

/* verification/tb_clk_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  // held low over three rising edges, released on a falling edge
  initial begin
    rst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* verification/tb_gfx_pattern_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "gfx_consts.svh"

module tb_gfx_pattern_top;

  localparam int LINE_LEN  = `GFX_H_LINE_END + 1;
  localparam int FRAME_LEN = LINE_LEN * (`GFX_V_FRAME_END + 1);

  logic              clk;
  logic              rst_n;
  logic              start;
  gfx_pkg::pattern_e mode;
  gfx_pkg::pixel_t   color;
  logic              busy;
  logic              fill_done;
  gfx_pkg::vga_t     vga;

  int case_mode [$];
  int case_color [$];
  int case_x [$];
  int case_y [$];
  int case_exp [$];
  int cycles = 0;
  int limit = 0;

  tb_clk_gen i_tb_clk_gen (
    .clk  (clk),
    .rst_n(rst_n)
  );

  gfx_pattern_top i_gfx_pattern_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (start),
    .mode     (mode),
    .color    (color),
    .busy     (busy),
    .fill_done(fill_done),
    .vga      (vga)
  );

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic compare_pixel(input string name, input gfx_pkg::pixel_t exp,
                               input gfx_pkg::pixel_t act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic compare_vga(input string name, input gfx_pkg::vga_t exp,
                             input gfx_pkg::vga_t act);
    if ({act.hsync, act.vsync, act.de} !== {exp.hsync, exp.vsync, exp.de}) begin
      stop_with_error($sformatf("MISMATCH %s hsync/vsync/de expected %b actual %b", name,
                                {exp.hsync, exp.vsync, exp.de}, {act.hsync, act.vsync, act.de}));
    end
  endtask

  task automatic compare_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      stop_with_error($sformatf("MISMATCH %s expected %b actual %b", name, exp, act));
    end
  endtask

  // reference colour for one visible pixel
  function automatic gfx_pkg::pixel_t pattern_pixel(input int m, input int c, input int x,
                                                    input int y);
    gfx_pkg::pixel_t p;
    int              bar;
    p   = '0;
    bar = x / 2;
    case (gfx_pkg::pattern_e'(2'(m)))
      gfx_pkg::PAT_SOLID: p = gfx_pkg::pixel_t'(12'(c));
      gfx_pkg::PAT_BARS: begin
        p.red   = (bar % 2 == 1) ? 4'hf : 4'h0;
        p.green = ((bar / 2) % 2 == 1) ? 4'hf : 4'h0;
        p.blue  = ((bar / 4) % 2 == 1) ? 4'hf : 4'h0;
      end
      gfx_pkg::PAT_CHECKER: begin
        if ((x / 4) % 2 != (y / 4) % 2) begin
          p = gfx_pkg::pixel_t'(12'(c));
        end
      end
      default: begin
        p.red   = 4'(x % 16);
        p.green = 4'(2 * y);
        p.blue  = 4'((x + y) % 16);
      end
    endcase
    return p;
  endfunction

  task automatic load_cases();
    int    fd;
    int    n;
    int    m, c, x, y, e;
    string line;
    fd = $fopen("verification/gfx_pattern_cases.txt", "r");
    if (fd == 0) begin
      stop_with_error("could not open verification/gfx_pattern_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#") begin
        if ($sscanf(line, "%h %h %d %d %h", m, c, x, y, e) == 5) begin
          case_mode.push_back(m);
          case_color.push_back(c);
          case_x.push_back(x);
          case_y.push_back(y);
          case_exp.push_back(e);
        end
      end
    end
    $fclose(fd);
    if (case_mode.size() == 0) begin
      stop_with_error("the case file holds no usable case lines");
    end
  endtask

  // one full frame starting at the first sample after vsync rises
  task automatic check_frame(input int idx);
    gfx_pkg::vga_t   exp_v;
    gfx_pkg::pixel_t exp_p;
    logic            prev_vsync;
    int              hh;
    int              line;
    string           name;
    prev_vsync = vga.vsync;
    @(negedge clk);
    while (!(vga.vsync && !prev_vsync)) begin
      prev_vsync = vga.vsync;
      compare_flag($sformatf("case %0d busy while idle", idx), 1'b0, busy);
      @(negedge clk);
    end
    for (int k = 0; k < FRAME_LEN; k++) begin
      hh          = k % LINE_LEN;
      line        = (`GFX_V_FRAME_END + k / LINE_LEN) % (`GFX_V_FRAME_END + 1);
      exp_v       = '0;
      exp_v.de    = (hh < `GFX_H_VISIBLE) && (line < `GFX_V_VISIBLE);
      exp_v.hsync = !((hh >= `GFX_H_SYNC_START) && (hh < `GFX_H_SYNC_END));
      exp_v.vsync = !((line >= `GFX_V_SYNC_START) && (line < `GFX_V_SYNC_END));
      exp_p       = exp_v.de ? pattern_pixel(case_mode[idx], case_color[idx], hh, line) : '0;
      name        = $sformatf("case %0d h %0d v %0d", idx, hh, line);
      if (exp_v.de && hh == case_x[idx] && line == case_y[idx]) begin
        compare_pixel({name, " spot"}, gfx_pkg::pixel_t'(12'(case_exp[idx])), vga.color);
      end
      compare_vga(name, exp_v, vga);
      compare_pixel(name, exp_p, vga.color);
      compare_flag({name, " fill_done"}, 1'b0, fill_done);
      @(negedge clk);
    end
  endtask

  task automatic run_case(input int idx);
    int unsigned gap;
    gap = $urandom % 8;
    repeat (gap) @(negedge clk);
    mode  = gfx_pkg::pattern_e'(2'(case_mode[idx]));
    color = gfx_pkg::pixel_t'(12'(case_color[idx]));
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    repeat (4) @(negedge clk);
    compare_flag($sformatf("case %0d busy during fill", idx), 1'b1, busy);
    // a second start mid-fill with other settings must leave no trace
    mode  = gfx_pkg::pattern_e'(2'(case_mode[idx]) ^ 2'd1);
    color = gfx_pkg::pixel_t'(~12'(case_color[idx]));
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    while (fill_done !== 1'b1) begin
      compare_flag($sformatf("case %0d busy before done", idx), 1'b1, busy);
      @(negedge clk);
    end
    @(negedge clk);
    compare_flag($sformatf("case %0d fill_done pulse width", idx), 1'b0, fill_done);
    compare_flag($sformatf("case %0d busy after done", idx), 1'b0, busy);
    check_frame(idx);
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (limit > 0 && cycles >= limit) begin
      stop_with_error($sformatf("timeout after %0d cycles, a fill or frame never finished",
                                cycles));
    end
  end

  initial begin
    start = 1'b0;
    mode  = gfx_pkg::PAT_SOLID;
    color = '0;
    void'($urandom(32'h3f82_88f0));
    load_cases();
    limit = case_mode.size() * (`GFX_FB_DEPTH * 2 + 3 * FRAME_LEN) + 100;
    wait (rst_n === 1'b1);
    @(negedge clk);
    compare_flag("busy after reset", 1'b0, busy);
    compare_flag("fill_done after reset", 1'b0, fill_done);
    compare_flag("de after reset", 1'b0, vga.de);
    foreach (case_mode[i]) begin
      run_case(i);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* verification/gfx_pattern_cases.txt */
# mode (hex: 0 solid, 1 bars, 2 checker, 3 gradient), colour (hex rgb),
# spot x, spot y (decimal), expected pixel at the spot (hex rgb)
0 5a3 3 2 5a3
1 000 11 4 f0f
2 0c7 4 1 0c7
3 123 13 6 dc3
2 e21 5 5 000
1 777 15 7 fff
0 9be 15 7 9be
3 000 0 7 0e7

/* gfx_pattern.f */
+incdir+hdl
hdl/gfx_pkg.sv
hdl/gfx_pattern.sv
hdl/gfx_fb_writer.sv
hdl/gfx_fb_mem.sv
hdl/gfx_scanout.sv
hdl/gfx_pattern_top.sv
verification/tb_clk_gen.sv
verification/tb_gfx_pattern_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the framebuffer pattern testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 \
  -f gfx_pattern.f \
  --top-module tb_gfx_pattern_top \
  -o tb_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Finished with no errors$" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
